/* src/axi_remap_pkg.sv */
// shared widths, AXI channel and port structs and rule type for the address remapper
`default_nettype none

package axi_remap_pkg;

  // port widths
  localparam int unsigned SlvAddrWidth = 32;
  localparam int unsigned MstAddrWidth = 40;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned IdWidth      = 4;
  localparam int unsigned UserWidth    = 1;
  // default depth of the rule table
  localparam int unsigned NumRules     = 4;

  typedef logic [SlvAddrWidth-1:0]  slv_addr_t;
  typedef logic [MstAddrWidth-1:0]  mst_addr_t;
  typedef logic [IdWidth-1:0]       id_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [DataWidth/8-1:0]   strb_t;
  typedef logic [UserWidth-1:0]     user_t;
  typedef logic [7:0]               len_t;
  typedef logic [1:0]               resp_code_t;
  typedef logic [1:0]               rule_idx_t;

  // AXI response encodings
  localparam resp_code_t RespOkay   = 2'b00;
  localparam resp_code_t RespDecerr = 2'b11;

  // address write channel, one per address width
  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    logic [5:0] atop;
    user_t      user;
  } slv_aw_chan_t;

  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    logic [5:0] atop;
    user_t      user;
  } mst_aw_chan_t;

  // address read channel, same fields minus atop
  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    user_t      user;
  } slv_ar_chan_t;

  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    len_t       len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    user_t      user;
  } mst_ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } w_chan_t;

  typedef struct packed {
    id_t        id;
    resp_code_t resp;
    user_t      user;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    data_t      data;
    resp_code_t resp;
    logic       last;
    user_t      user;
  } r_chan_t;

  // request bundles differ only in the address channel types
  typedef struct packed {
    slv_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    slv_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } slv_req_t;

  typedef struct packed {
    mst_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    mst_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } mst_req_t;

  // response bundle shared by both ports
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } resp_t;

  // one translation rule
  typedef struct packed {
    logic      valid;
    slv_addr_t slv_base;
    slv_addr_t mask;
    mst_addr_t mst_base;
  } remap_rule_t;

endpackage

`default_nettype wire

/* src/axi_addr_reg.sv */
// input register slice for AW and AR, lets the rule lookup start from a registered address
`timescale 1ns/100ps
`default_nettype none

module axi_addr_reg (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // slave port
  input  axi_remap_pkg::slv_req_t slv_req_i,
  output axi_remap_pkg::resp_t    slv_resp_o,
  // registered side towards the lookup
  output axi_remap_pkg::slv_req_t reg_req_o,
  input  axi_remap_pkg::resp_t    reg_resp_i
);

  import axi_remap_pkg::*;

  // one entry per address channel
  slv_aw_chan_t aw_q;
  logic         aw_valid_q;
  logic         aw_ready;
  slv_ar_chan_t ar_q;
  logic         ar_valid_q;
  logic         ar_ready;

  // stage can take a new beat when empty or when its beat leaves this cycle
  assign aw_ready = ~aw_valid_q | reg_resp_i.aw_ready;
  assign ar_ready = ~ar_valid_q | reg_resp_i.ar_ready;

  // valid flags
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_valid_q <= 1'b0;
      ar_valid_q <= 1'b0;
    end else begin
      if (aw_ready) begin
        aw_valid_q <= slv_req_i.aw_valid;
      end
      if (ar_ready) begin
        ar_valid_q <= slv_req_i.ar_valid;
      end
    end
  end

  // payload only loads on an accepted beat
  always_ff @(posedge clk_i) begin
    if (aw_ready && slv_req_i.aw_valid) begin
      aw_q <= slv_req_i.aw;
    end
    if (ar_ready && slv_req_i.ar_valid) begin
      ar_q <= slv_req_i.ar;
    end
  end

  // W, b_ready and r_ready go straight through
  always_comb begin
    reg_req_o          = slv_req_i;
    reg_req_o.aw       = aw_q;
    reg_req_o.aw_valid = aw_valid_q;
    reg_req_o.ar       = ar_q;
    reg_req_o.ar_valid = ar_valid_q;
  end

  // B, R and w_ready come from downstream, the address readies are local
  always_comb begin
    slv_resp_o          = reg_resp_i;
    slv_resp_o.aw_ready = aw_ready;
    slv_resp_o.ar_ready = ar_ready;
  end

endmodule

`default_nettype wire

/* src/axi_remap_table.sv */
// rule registers plus the AW and AR priority lookups that give the master address
`timescale 1ns/100ps
`default_nettype none

module axi_remap_table #(
  parameter int unsigned NumRules = axi_remap_pkg::NumRules
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // rule programming
  input  logic                       cfg_we_i,
  input  axi_remap_pkg::rule_idx_t   cfg_idx_i,
  input  axi_remap_pkg::remap_rule_t cfg_rule_i,
  // addresses to translate
  input  axi_remap_pkg::slv_addr_t   aw_addr_i,
  input  axi_remap_pkg::slv_addr_t   ar_addr_i,
  // translated addresses and match flags
  output axi_remap_pkg::mst_addr_t   aw_addr_o,
  output axi_remap_pkg::mst_addr_t   ar_addr_o,
  output logic                       aw_hit_o,
  output logic                       ar_hit_o
);

  import axi_remap_pkg::*;

  remap_rule_t rules_q [NumRules];

  // bits selected by the mask must equal the base
  function automatic logic rule_match(remap_rule_t rule, slv_addr_t addr);
    return rule.valid && ((addr & rule.mask) == rule.slv_base);
  endfunction

  // unmasked offset bits are zero extended and merged into the master base
  function automatic mst_addr_t rule_map(remap_rule_t rule, slv_addr_t addr);
    return rule.mst_base | mst_addr_t'(addr & ~rule.mask);
  endfunction

  // table comes out of reset with every rule invalid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NumRules; i++) begin
        rules_q[i].valid <= 1'b0;
      end
    end else if (cfg_we_i && (32'(cfg_idx_i) < NumRules)) begin
      rules_q[cfg_idx_i] <= cfg_rule_i;
    end
  end

  // walk from the top so the lowest matching index is the last one written
  always_comb begin
    aw_hit_o  = 1'b0;
    aw_addr_o = mst_addr_t'(aw_addr_i);
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (rule_match(rules_q[i], aw_addr_i)) begin
        aw_hit_o  = 1'b1;
        aw_addr_o = rule_map(rules_q[i], aw_addr_i);
      end
    end
  end

  // same priority scheme for reads
  always_comb begin
    ar_hit_o  = 1'b0;
    ar_addr_o = mst_addr_t'(ar_addr_i);
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (rule_match(rules_q[i], ar_addr_i)) begin
        ar_hit_o  = 1'b1;
        ar_addr_o = rule_map(rules_q[i], ar_addr_i);
      end
    end
  end

endmodule

`default_nettype wire

/* src/axi_modify_address.sv */
// swaps the AW and AR addresses for the translated ones, all other fields pass untouched
`timescale 1ns/100ps
`default_nettype none

module axi_modify_address (
  // slave side, 32-bit addresses
  input  axi_remap_pkg::slv_req_t  slv_req_i,
  output axi_remap_pkg::resp_t     slv_resp_o,
  // master side, 40-bit addresses
  output axi_remap_pkg::mst_req_t  mst_req_o,
  input  axi_remap_pkg::resp_t     mst_resp_i,
  input  axi_remap_pkg::mst_addr_t mst_aw_addr_i,
  input  axi_remap_pkg::mst_addr_t mst_ar_addr_i
);

  always_comb begin
    // write address, atop is carried as is
    mst_req_o.aw.id     = slv_req_i.aw.id;
    mst_req_o.aw.addr   = mst_aw_addr_i;
    mst_req_o.aw.len    = slv_req_i.aw.len;
    mst_req_o.aw.size   = slv_req_i.aw.size;
    mst_req_o.aw.burst  = slv_req_i.aw.burst;
    mst_req_o.aw.lock   = slv_req_i.aw.lock;
    mst_req_o.aw.cache  = slv_req_i.aw.cache;
    mst_req_o.aw.prot   = slv_req_i.aw.prot;
    mst_req_o.aw.qos    = slv_req_i.aw.qos;
    mst_req_o.aw.region = slv_req_i.aw.region;
    mst_req_o.aw.atop   = slv_req_i.aw.atop;
    mst_req_o.aw.user   = slv_req_i.aw.user;
    mst_req_o.aw_valid  = slv_req_i.aw_valid;
    // write data and response ready
    mst_req_o.w         = slv_req_i.w;
    mst_req_o.w_valid   = slv_req_i.w_valid;
    mst_req_o.b_ready   = slv_req_i.b_ready;
    // read address
    mst_req_o.ar.id     = slv_req_i.ar.id;
    mst_req_o.ar.addr   = mst_ar_addr_i;
    mst_req_o.ar.len    = slv_req_i.ar.len;
    mst_req_o.ar.size   = slv_req_i.ar.size;
    mst_req_o.ar.burst  = slv_req_i.ar.burst;
    mst_req_o.ar.lock   = slv_req_i.ar.lock;
    mst_req_o.ar.cache  = slv_req_i.ar.cache;
    mst_req_o.ar.prot   = slv_req_i.ar.prot;
    mst_req_o.ar.qos    = slv_req_i.ar.qos;
    mst_req_o.ar.region = slv_req_i.ar.region;
    mst_req_o.ar.user   = slv_req_i.ar.user;
    mst_req_o.ar_valid  = slv_req_i.ar_valid;
    mst_req_o.r_ready   = slv_req_i.r_ready;
  end

  // responses do not carry an address
  assign slv_resp_o = mst_resp_i;

endmodule

`default_nettype wire

/* src/axi_decerr_demux.sv */
// forwards mapped requests to the master port and answers unmapped ones with DECERR in order
`timescale 1ns/100ps
`default_nettype none

module axi_decerr_demux (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // translated requests and their lookup result
  input  axi_remap_pkg::mst_req_t req_i,
  output axi_remap_pkg::resp_t    resp_o,
  input  logic                    aw_hit_i,
  input  logic                    ar_hit_i,
  // master port
  output axi_remap_pkg::mst_req_t mst_req_o,
  input  axi_remap_pkg::resp_t    mst_resp_i
);

  import axi_remap_pkg::*;

  typedef enum logic [1:0] {WrIdle, WrDrain, WrResp} wr_state_e;
  typedef enum logic {RdIdle, RdBeat} rd_state_e;

  // outstanding limit per direction
  localparam logic [3:0] CntMax = 4'd15;

  wr_state_e  wr_state_q;
  rd_state_e  rd_state_q;
  logic [3:0] wr_cnt_q;
  logic [3:0] rd_cnt_q;
  // forwarded AWs whose W burst has not finished yet
  logic [3:0] w_fwd_q;
  id_t        err_wr_id_q;
  id_t        err_rd_id_q;
  len_t       err_len_q;
  len_t       err_beat_q;

  logic aw_fwd_ok, aw_err_ok, aw_fwd, aw_err;
  logic ar_fwd_ok, ar_err_ok, ar_fwd, ar_err;
  logic w_open, w_fwd_last, w_drain_last, b_fwd;
  logic r_fwd_last, r_err_hs, r_err_last;

  // hits go out while no error is active, misses wait for an empty pipe
  assign aw_fwd_ok = (wr_state_q == WrIdle) && aw_hit_i && (wr_cnt_q != CntMax);
  assign aw_err_ok = (wr_state_q == WrIdle) && (wr_cnt_q == 4'd0);
  assign ar_fwd_ok = (rd_state_q == RdIdle) && ar_hit_i && (rd_cnt_q != CntMax);
  assign ar_err_ok = (rd_state_q == RdIdle) && (rd_cnt_q == 4'd0);

  assign aw_fwd = req_i.aw_valid && aw_fwd_ok && mst_resp_i.aw_ready;
  assign aw_err = req_i.aw_valid && !aw_hit_i && aw_err_ok;
  assign ar_fwd = req_i.ar_valid && ar_fwd_ok && mst_resp_i.ar_ready;
  assign ar_err = req_i.ar_valid && !ar_hit_i && ar_err_ok;

  // W only goes downstream once its AW has been forwarded
  assign w_open       = (w_fwd_q != 4'd0);
  assign w_fwd_last   = req_i.w_valid && w_open && mst_resp_i.w_ready && req_i.w.last;
  assign w_drain_last = (wr_state_q == WrDrain) && req_i.w_valid && req_i.w.last;
  assign b_fwd        = mst_resp_i.b_valid && req_i.b_ready && (wr_state_q != WrResp);

  assign r_fwd_last = mst_resp_i.r_valid && req_i.r_ready && mst_resp_i.r.last
                      && (rd_state_q != RdBeat);
  assign r_err_hs   = (rd_state_q == RdBeat) && req_i.r_ready;
  assign r_err_last = (err_beat_q == err_len_q);

  // master port, payloads pass and handshakes are gated
  always_comb begin
    mst_req_o          = req_i;
    mst_req_o.aw_valid = req_i.aw_valid && aw_fwd_ok;
    mst_req_o.w_valid  = req_i.w_valid && w_open;
    mst_req_o.b_ready  = req_i.b_ready && (wr_state_q != WrResp);
    mst_req_o.ar_valid = req_i.ar_valid && ar_fwd_ok;
    mst_req_o.r_ready  = req_i.r_ready && (rd_state_q != RdBeat);
  end

  // upstream response, local DECERR beats take over while an error is active
  always_comb begin
    resp_o          = mst_resp_i;
    resp_o.aw_ready = aw_hit_i ? (aw_fwd_ok && mst_resp_i.aw_ready) : aw_err_ok;
    resp_o.ar_ready = ar_hit_i ? (ar_fwd_ok && mst_resp_i.ar_ready) : ar_err_ok;
    resp_o.w_ready  = (wr_state_q == WrDrain) || (w_open && mst_resp_i.w_ready);
    if (wr_state_q == WrResp) begin
      resp_o.b_valid = 1'b1;
      resp_o.b.id    = err_wr_id_q;
      resp_o.b.resp  = RespDecerr;
      resp_o.b.user  = '0;
    end
    if (rd_state_q == RdBeat) begin
      resp_o.r_valid = 1'b1;
      resp_o.r.id    = err_rd_id_q;
      resp_o.r.data  = '0;
      resp_o.r.resp  = RespDecerr;
      resp_o.r.last  = r_err_last;
      resp_o.r.user  = '0;
    end
  end

  // state machines and counters
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= WrIdle;
      rd_state_q <= RdIdle;
      wr_cnt_q   <= 4'd0;
      rd_cnt_q   <= 4'd0;
      w_fwd_q    <= 4'd0;
    end else begin
      wr_cnt_q <= wr_cnt_q + 4'(aw_fwd) - 4'(b_fwd);
      rd_cnt_q <= rd_cnt_q + 4'(ar_fwd) - 4'(r_fwd_last);
      w_fwd_q  <= w_fwd_q + 4'(aw_fwd) - 4'(w_fwd_last);
      case (wr_state_q)
        WrIdle:  if (aw_err) wr_state_q <= WrDrain;
        WrDrain: if (w_drain_last) wr_state_q <= WrResp;
        WrResp:  if (req_i.b_ready) wr_state_q <= WrIdle;
        default: wr_state_q <= WrIdle;
      endcase
      case (rd_state_q)
        RdIdle:  if (ar_err) rd_state_q <= RdBeat;
        RdBeat:  if (r_err_hs && r_err_last) rd_state_q <= RdIdle;
        default: rd_state_q <= RdIdle;
      endcase
    end
  end

  // error transaction context
  always_ff @(posedge clk_i) begin
    if (aw_err) begin
      err_wr_id_q <= req_i.aw.id;
    end
    if (ar_err) begin
      err_rd_id_q <= req_i.ar.id;
      err_len_q   <= req_i.ar.len;
      err_beat_q  <= '0;
    end else if (r_err_hs) begin
      err_beat_q  <= err_beat_q + 8'd1;
    end
  end

endmodule

`default_nettype wire

/* src/axi_remap_top.sv */
// address remapper top, register slice then rule lookup, address swap and DECERR demux
`timescale 1ns/100ps
`default_nettype none

module axi_remap_top #(
  parameter int unsigned NumRules = axi_remap_pkg::NumRules
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // rule programming
  input  logic                       cfg_we_i,
  input  axi_remap_pkg::rule_idx_t   cfg_idx_i,
  input  axi_remap_pkg::remap_rule_t cfg_rule_i,
  // slave port, 32-bit addresses
  input  axi_remap_pkg::slv_req_t    slv_req_i,
  output axi_remap_pkg::resp_t       slv_resp_o,
  // master port, 40-bit addresses
  output axi_remap_pkg::mst_req_t    mst_req_o,
  input  axi_remap_pkg::resp_t       mst_resp_i
);

  import axi_remap_pkg::*;

  slv_req_t  reg_req;
  resp_t     reg_resp;
  mst_req_t  mod_req;
  resp_t     mod_resp;
  mst_addr_t aw_mst_addr;
  mst_addr_t ar_mst_addr;
  logic      aw_hit;
  logic      ar_hit;

  axi_addr_reg i_addr_reg (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .slv_req_i  ( slv_req_i  ),
    .slv_resp_o ( slv_resp_o ),
    .reg_req_o  ( reg_req    ),
    .reg_resp_i ( reg_resp   )
  );

  // lookup runs on the registered addresses
  axi_remap_table #(
    .NumRules ( NumRules )
  ) i_remap_table (
    .clk_i      ( clk_i            ),
    .reset_i    ( reset_i          ),
    .cfg_we_i   ( cfg_we_i         ),
    .cfg_idx_i  ( cfg_idx_i        ),
    .cfg_rule_i ( cfg_rule_i       ),
    .aw_addr_i  ( reg_req.aw.addr  ),
    .ar_addr_i  ( reg_req.ar.addr  ),
    .aw_addr_o  ( aw_mst_addr      ),
    .ar_addr_o  ( ar_mst_addr      ),
    .aw_hit_o   ( aw_hit           ),
    .ar_hit_o   ( ar_hit           )
  );

  axi_modify_address i_modify_address (
    .slv_req_i     ( reg_req     ),
    .slv_resp_o    ( reg_resp    ),
    .mst_req_o     ( mod_req     ),
    .mst_resp_i    ( mod_resp    ),
    .mst_aw_addr_i ( aw_mst_addr ),
    .mst_ar_addr_i ( ar_mst_addr )
  );

  axi_decerr_demux i_decerr_demux (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .req_i      ( mod_req    ),
    .resp_o     ( mod_resp   ),
    .aw_hit_i   ( aw_hit     ),
    .ar_hit_i   ( ar_hit     ),
    .mst_req_o  ( mst_req_o  ),
    .mst_resp_i ( mst_resp_i )
  );

endmodule

`default_nettype wire

/* dv/axi_remap_asserts.sv */
// protocol checks on the remapper ports, attached to every axi_remap_top by bind
`timescale 1ns/100ps
`default_nettype none

module axi_remap_asserts (
  input logic                    clk_i,
  input logic                    reset_i,
  input axi_remap_pkg::slv_req_t slv_req_i,
  input axi_remap_pkg::resp_t    slv_resp_o,
  input axi_remap_pkg::mst_req_t mst_req_o,
  input axi_remap_pkg::resp_t    mst_resp_i
);

  import axi_remap_pkg::*;

  // finished W bursts minus B handshakes on the slave port
  int   w_bursts_q;
  logic rst_seen_q = 1'b0;

  always_ff @(posedge clk_i) begin
    rst_seen_q <= rst_seen_q | reset_i;
    if (reset_i) begin
      w_bursts_q <= 0;
    end else begin
      w_bursts_q <= w_bursts_q
                    + int'(slv_req_i.w_valid && slv_resp_o.w_ready && slv_req_i.w.last)
                    - int'(slv_resp_o.b_valid && slv_req_i.b_ready);
    end
  end

  // master AW holds with its payload until taken
  mst_aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_req_o.aw_valid && !mst_resp_i.aw_ready |=> mst_req_o.aw_valid && $stable(mst_req_o.aw))
    else $error("master AW dropped or changed before ready");

  // slave R holds with its payload until taken
  slv_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_resp_o.r_valid && !slv_req_i.r_ready |=> slv_resp_o.r_valid && $stable(slv_resp_o.r))
    else $error("slave R dropped or changed before ready");

  // a B never comes ahead of the last W of its burst
  b_after_w: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_resp_o.b_valid |-> w_bursts_q > 0)
    else $error("B raised before all W beats were taken");

  // once reset has been clocked in, all valids stay low
  rst_quiet: assert property (@(posedge clk_i)
    reset_i && rst_seen_q |-> !mst_req_o.aw_valid && !mst_req_o.ar_valid
      && !mst_req_o.w_valid && !slv_resp_o.b_valid && !slv_resp_o.r_valid)
    else $error("valid high during reset");

endmodule

bind axi_remap_top axi_remap_asserts i_asserts (.*);

`default_nettype wire

/* dv/tb_axi_remap.sv */
// testbench for axi_remap_top, runs a table of rule writes and transactions against a slave model
`timescale 1ns/100ps
`default_nettype none

module tb_axi_remap;

  import axi_remap_pkg::*;

  typedef enum {OpRule, OpWrite, OpRead} op_e;
  typedef struct {
    string       name;
    op_e         op;
    slv_addr_t   addr;
    len_t        len;
    logic        hit;
    mst_addr_t   exp_addr;
    rule_idx_t   idx;
    remap_rule_t rule;
  } entry_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        cfg_we;
  rule_idx_t   cfg_idx;
  remap_rule_t cfg_rule;
  slv_req_t    slv_req;
  resp_t       slv_resp;
  mst_req_t    mst_req;
  resp_t       mst_resp = '0;

  entry_t       tbl[$];
  // entries issued back to back per direction
  entry_t       mix[$];
  int           cycles = 0;
  int           limit = 0;
  logic [15:0]  drv_lfsr = 16'd6;
  logic [15:0]  mdl_lfsr = 16'd6;
  // W data of mapped writes, in the order it must reach the master port
  data_t        w_exp[$];
  // slave model state
  mst_aw_chan_t aw_seen[$];
  mst_ar_chan_t ar_seen[$];
  id_t          b_pend[$];
  mst_ar_chan_t r_pend[$];
  int           w_done = 0;
  int           r_beat = 0;

  axi_remap_top #(.NumRules(NumRules)) dut (
    .clk_i(clk), .reset_i(reset), .cfg_we_i(cfg_we), .cfg_idx_i(cfg_idx),
    .cfg_rule_i(cfg_rule), .slv_req_i(slv_req), .slv_resp_o(slv_resp),
    .mst_req_o(mst_req), .mst_resp_i(mst_resp)
  );

  always #20 clk = ~clk;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic drv_bit();
    drv_lfsr = lfsr_step(drv_lfsr);
    return drv_lfsr[0];
  endfunction

  function automatic logic mdl_bit();
    mdl_lfsr = lfsr_step(mdl_lfsr);
    return mdl_lfsr[0];
  endfunction

  function automatic data_t rand_word();
    data_t w;
    for (int i = 0; i < DataWidth; i++) begin
      w[i] = drv_bit();
    end
    return w;
  endfunction

  task automatic fail_stop();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_mst_addr(input string name, input mst_addr_t exp, input mst_addr_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_resp(input string name, input resp_code_t exp, input resp_code_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected resp %0d, actual %0d", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected data %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_count(input string name, input len_t exp, input len_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected id %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic add_rule(input string name, input rule_idx_t idx, input logic valid,
                          input slv_addr_t base, input slv_addr_t mask, input mst_addr_t mbase);
    entry_t e;
    e.name = name;
    e.op = OpRule;
    e.idx = idx;
    e.rule = '{valid: valid, slv_base: base, mask: mask, mst_base: mbase};
    tbl.push_back(e);
  endtask

  task automatic add_txn(input string name, input op_e op, input slv_addr_t addr,
                         input len_t len, input logic hit, input mst_addr_t exp);
    entry_t e;
    e.name = name;
    e.op = op;
    e.addr = addr;
    e.len = len;
    e.hit = hit;
    e.exp_addr = exp;
    e.rule = '0;
    tbl.push_back(e);
  endtask

  task automatic add_mix(input string name, input op_e op, input slv_addr_t addr,
                         input len_t len, input logic hit, input mst_addr_t exp);
    add_txn(name, op, addr, len, hit, exp);
    mix.push_back(tbl.pop_back());
  endtask

  task automatic build_table();
    add_rule("rule0", 2'd0, 1'b1, 32'h1000_0000, 32'hF000_0000, 40'hA0_0000_0000);
    // rule 1 sits inside rule 0 and is shadowed while rule 0 is valid
    add_rule("rule1", 2'd1, 1'b1, 32'h1000_0000, 32'hFF00_0000, 40'hB1_0000_0000);
    add_rule("rule2", 2'd2, 1'b1, 32'h2000_0000, 32'hFFFF_0000, 40'hC2_0000_0000);
    add_rule("rule3", 2'd3, 1'b1, 32'h3000_0000, 32'hF000_0000, 40'h00_4000_0000);
    add_txn("wr_rule0", OpWrite, 32'h1234_5678, 8'd1, 1'b1, 40'hA0_0234_5678);
    add_txn("rd_overlap0", OpRead, 32'h1000_0040, 8'd3, 1'b1, 40'hA0_0000_0040);
    add_txn("wr_rule2", OpWrite, 32'h2000_0ABC, 8'd0, 1'b1, 40'hC2_0000_0ABC);
    add_txn("rd_rule3", OpRead, 32'h3000_1000, 8'd2, 1'b1, 40'h00_4000_1000);
    add_txn("wr_miss", OpWrite, 32'h5000_0000, 8'd3, 1'b0, '0);
    add_txn("rd_miss", OpRead, 32'h7000_0040, 8'd4, 1'b0, '0);
    add_rule("rule0_off", 2'd0, 1'b0, 32'h1000_0000, 32'hF000_0000, 40'hA0_0000_0000);
    add_txn("rd_rule1", OpRead, 32'h1000_0040, 8'd1, 1'b1, 40'hB1_0000_0040);
    add_txn("wr_rule1", OpWrite, 32'h1012_3456, 8'd2, 1'b1, 40'hB1_0012_3456);
    add_txn("wr_old0_miss", OpWrite, 32'h1234_5678, 8'd0, 1'b0, '0);
    // mixed hits and misses, a miss lands behind an outstanding hit and a hit behind a miss
    add_mix("rd_mix_hit", OpRead, 32'h2000_0100, 8'd2, 1'b1, 40'hC2_0000_0100);
    add_mix("wr_mix_first", OpWrite, 32'h2000_0200, 8'd1, 1'b1, 40'hC2_0000_0200);
    add_mix("wr_mix_miss", OpWrite, 32'h6000_0000, 8'd1, 1'b0, '0);
    add_mix("rd_mix_miss", OpRead, 32'h8000_0000, 8'd0, 1'b0, '0);
    add_mix("wr_mix_hit", OpWrite, 32'h3000_0004, 8'd3, 1'b1, 40'h00_4000_0004);
    add_mix("rd_mix_after", OpRead, 32'h3000_0040, 8'd1, 1'b1, 40'h00_4000_0040);
  endtask

  task automatic run_rule(input entry_t e);
    @(negedge clk);
    cfg_we = 1'b1;
    cfg_idx = e.idx;
    cfg_rule = e.rule;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // AW handshake, then every W beat of the burst
  task automatic send_write(input entry_t e, input id_t id);
    data_t d;
    @(negedge clk);
    slv_req.aw = '0;
    slv_req.aw.id = id;
    slv_req.aw.addr = e.addr;
    slv_req.aw.len = e.len;
    slv_req.aw.size = 3'd2;
    slv_req.aw.burst = 2'b01;
    slv_req.aw_valid = 1'b1;
    @(posedge clk);
    while (!slv_resp.aw_ready) @(posedge clk);
    @(negedge clk);
    slv_req.aw_valid = 1'b0;
    for (int i = 0; i <= int'(e.len); i++) begin
      d = rand_word();
      // only beats of a mapped write may show up downstream
      if (e.hit) w_exp.push_back(d);
      slv_req.w.data = d;
      slv_req.w.strb = '1;
      slv_req.w.last = (len_t'(i) == e.len);
      slv_req.w_valid = 1'b1;
      @(posedge clk);
      while (!slv_resp.w_ready) @(posedge clk);
      @(negedge clk);
    end
    slv_req.w_valid = 1'b0;
  endtask

  // waits for the B of the oldest write and checks it against its AW on the master port
  task automatic collect_write(input entry_t e, input id_t id);
    mst_aw_chan_t a;
    slv_req.b_ready = drv_bit();
    forever begin
      @(posedge clk);
      if (slv_resp.b_valid && slv_req.b_ready) break;
      @(negedge clk);
      slv_req.b_ready = drv_bit();
    end
    check_resp(e.name, e.hit ? RespOkay : RespDecerr, slv_resp.b.resp);
    check_id(e.name, id, slv_resp.b.id);
    if (e.hit) begin
      if (aw_seen.size() == 0) begin
        $display("%s: no AW request reached the master port", e.name);
        fail_stop();
      end
      a = aw_seen.pop_front();
      check_mst_addr(e.name, e.exp_addr, a.addr);
      check_count({e.name, " aw len"}, e.len, a.len);
      check_id({e.name, " aw id"}, id, a.id);
    end else if (aw_seen.size() != 0) begin
      $display("%s: an unmapped write reached the master port", e.name);
      fail_stop();
    end
    @(negedge clk);
    slv_req.b_ready = 1'b0;
  endtask

  task automatic send_read(input entry_t e, input id_t id);
    @(negedge clk);
    slv_req.ar = '0;
    slv_req.ar.id = id;
    slv_req.ar.addr = e.addr;
    slv_req.ar.len = e.len;
    slv_req.ar.size = 3'd2;
    slv_req.ar.burst = 2'b01;
    slv_req.ar_valid = 1'b1;
    @(posedge clk);
    while (!slv_resp.ar_ready) @(posedge clk);
    @(negedge clk);
    slv_req.ar_valid = 1'b0;
  endtask

  // takes every R beat of the oldest read, then checks its AR on the master port
  task automatic collect_read(input entry_t e, input id_t id);
    len_t beat;
    mst_ar_chan_t a;
    beat = '0;
    slv_req.r_ready = drv_bit();
    forever begin
      @(posedge clk);
      if (slv_resp.r_valid && slv_req.r_ready) begin
        check_resp(e.name, e.hit ? RespOkay : RespDecerr, slv_resp.r.resp);
        check_id(e.name, id, slv_resp.r.id);
        // hit data is the low master address plus the beat index
        if (e.hit) check_data(e.name, e.exp_addr[31:0] + data_t'(beat), slv_resp.r.data);
        if (slv_resp.r.last || beat == e.len) begin
          check_count({e.name, " beats"}, e.len, beat);
          check_count({e.name, " last"}, 8'd1, len_t'(slv_resp.r.last));
          break;
        end
        beat++;
      end
      @(negedge clk);
      slv_req.r_ready = drv_bit();
    end
    if (e.hit) begin
      if (ar_seen.size() == 0) begin
        $display("%s: no AR request reached the master port", e.name);
        fail_stop();
      end
      a = ar_seen.pop_front();
      check_mst_addr(e.name, e.exp_addr, a.addr);
      check_count({e.name, " ar len"}, e.len, a.len);
      check_id({e.name, " ar id"}, id, a.id);
    end else if (ar_seen.size() != 0) begin
      $display("%s: an unmapped read reached the master port", e.name);
      fail_stop();
    end
    @(negedge clk);
    slv_req.r_ready = 1'b0;
  endtask

  task automatic run_write(input entry_t e, input id_t id);
    send_write(e, id);
    collect_write(e, id);
  endtask

  task automatic run_read(input entry_t e, input id_t id);
    send_read(e, id);
    collect_read(e, id);
  endtask

  // requests of one direction go out without waiting for earlier responses,
  // responses are collected in request order
  task automatic run_mix();
    fork
      begin
        foreach (mix[i]) begin
          if (mix[i].op == OpWrite) send_write(mix[i], id_t'(i));
        end
      end
      begin
        foreach (mix[i]) begin
          if (mix[i].op == OpWrite) collect_write(mix[i], id_t'(i));
        end
      end
      begin
        foreach (mix[i]) begin
          if (mix[i].op == OpRead) send_read(mix[i], id_t'(i));
        end
      end
      begin
        foreach (mix[i]) begin
          if (mix[i].op == OpRead) collect_read(mix[i], id_t'(i));
        end
      end
    join
  endtask

  // slave model monitor, records master port handshakes
  always @(posedge clk) begin
    if (!reset) begin
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        aw_seen.push_back(mst_req.aw);
        b_pend.push_back(mst_req.aw.id);
      end
      if (mst_req.w_valid && mst_resp.w_ready) begin
        if (w_exp.size() == 0) begin
          $display("a W beat reached the master port without a mapped write");
          fail_stop();
        end
        check_data("master W data", w_exp.pop_front(), mst_req.w.data);
        if (mst_req.w.last) w_done++;
      end
      if (mst_resp.b_valid && mst_req.b_ready) begin
        void'(b_pend.pop_front());
        w_done--;
      end
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        ar_seen.push_back(mst_req.ar);
        r_pend.push_back(mst_req.ar);
      end
      if (mst_resp.r_valid && mst_req.r_ready) begin
        if (mst_resp.r.last) begin
          void'(r_pend.pop_front());
          r_beat = 0;
        end else begin
          r_beat++;
        end
      end
    end
  end

  // slave model driver, stalls readies about a quarter of the time
  always @(negedge clk) begin
    if (reset) begin
      mst_resp <= '0;
    end else begin
      mst_resp.aw_ready <= !(mdl_bit() & mdl_bit());
      mst_resp.ar_ready <= !(mdl_bit() & mdl_bit());
      mst_resp.w_ready  <= !(mdl_bit() & mdl_bit());
      mst_resp.b_valid  <= (b_pend.size() > 0) && (w_done > 0);
      mst_resp.b.id     <= (b_pend.size() > 0) ? b_pend[0] : '0;
      mst_resp.b.resp   <= RespOkay;
      mst_resp.b.user   <= '0;
      mst_resp.r_valid  <= (r_pend.size() > 0);
      if (r_pend.size() > 0) begin
        mst_resp.r.id   <= r_pend[0].id;
        mst_resp.r.data <= r_pend[0].addr[31:0] + data_t'(r_beat);
        mst_resp.r.last <= (r_beat == int'(r_pend[0].len));
      end
      mst_resp.r.resp   <= RespOkay;
      mst_resp.r.user   <= '0;
    end
  end

  // run length guard
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: run took more than %0d cycles", limit);
      fail_stop();
    end
  end

  initial begin
    reset = 1'b1;
    cfg_we = 1'b0;
    cfg_idx = '0;
    cfg_rule = '0;
    slv_req = '0;
    build_table();
    limit = 200;
    foreach (tbl[i]) begin
      if (tbl[i].op != OpRule) limit += (int'(tbl[i].len) + 1) * 8;
    end
    foreach (mix[i]) begin
      limit += (int'(mix[i].len) + 1) * 8;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;
    foreach (tbl[i]) begin
      case (tbl[i].op)
        OpRule:  run_rule(tbl[i]);
        OpWrite: run_write(tbl[i], id_t'(i));
        default: run_read(tbl[i], id_t'(i));
      endcase
    end
    run_mix();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/axi_remap_pkg.sv
src/axi_addr_reg.sv
src/axi_remap_table.sv
src/axi_modify_address.sv
src/axi_decerr_demux.sv
src/axi_remap_top.sv
dv/axi_remap_asserts.sv
dv/tb_axi_remap.sv

/* Makefile */
# Verilator build for the AXI address remapper testbench
VERILATOR ?= verilator
TOP       ?= tb_axi_remap
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)
